/* Bender.yml */
package:
  name: glb_cfg

sources:
  - include_dirs:
      - .
    files:
      - glb_cfg_pkg.sv
      - glb_host_port.sv
      - glb_tile_regs.sv
      - glb_tile_cfg_ctrl.sv
      - glb_tile.sv
      - glb_east_term.sv
      - glb_cfg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - glb_cfg_checker.sv
      - tb_glb_cfg.sv

/* glb_cfg_checker.sv */
// ========================================
// config path protocol assertions
// bound onto the top level host ports
// ========================================
`timescale 1ns/10ps

module glb_cfg_checker (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic host_rd_valid,
    input logic host_rd_err,
    input logic wr_drop
);

    // response valid is a one-cycle pulse
    assert property (@(posedge clk) disable iff (reset) host_rd_valid |=> !host_rd_valid)
        else $error("host_rd_valid held for more than one cycle");

    // busy falls with the pulse, so look one cycle back
    assert property (@(posedge clk) disable iff (reset) host_rd_valid |-> $past(busy))
        else $error("host_rd_valid without an outstanding read");

    assert property (@(posedge clk) disable iff (reset) host_rd_err |-> host_rd_valid)
        else $error("host_rd_err without host_rd_valid");

    assert property (@(posedge clk) reset |-> !(busy | host_rd_valid | host_rd_err | wr_drop))
        else $error("output active during reset");

endmodule

bind glb_cfg_top glb_cfg_checker checker0 (
    .clk           (clk),
    .reset         (reset),
    .busy          (busy),
    .host_rd_valid (host_rd_valid),
    .host_rd_err   (host_rd_err),
    .wr_drop       (wr_drop)
);

/* glb_cfg_defines.svh */
// ========================================
// global buffer config path widths
// tile count and register slot count
// ========================================
`ifndef GLB_CFG_DEFINES_SVH
`define GLB_CFG_DEFINES_SVH

// register word
`define GLB_DATA_WIDTH 32

// register slots per tile, 16 addressable
`define GLB_REG_ADDR_WIDTH 4

// up to 8 tile ids on the bus
`define GLB_TILE_ID_WIDTH 3

// byte address, word aligned
`define GLB_BYTE_OFFSET 2
`define GLB_ADDR_WIDTH (`GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH + `GLB_TILE_ID_WIDTH)

// tiles present in the chain
`define GLB_NUM_TILES 4

// implemented slots, the rest answer with nack
`define GLB_NUM_REGS 12

`endif

/* glb_cfg_pkg.sv */
// ========================================
// global buffer config path types
// bus words and pio request/response
// ========================================
`include "glb_cfg_defines.svh"

package glb_cfg_pkg;

    typedef logic [`GLB_DATA_WIDTH-1:0]     cfg_data_t;
    typedef logic [`GLB_ADDR_WIDTH-1:0]     cfg_addr_t;
    typedef logic [`GLB_TILE_ID_WIDTH-1:0]  tile_id_t;
    typedef logic [`GLB_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // eastward write request
    typedef struct packed {
        logic      en;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

    // eastward read request
    typedef struct packed {
        logic      en;
        cfg_addr_t addr;
    } cfg_rd_t;

    // westward read response
    typedef struct packed {
        logic      valid;
        logic      err;
        cfg_data_t data;
    } cfg_rsp_t;

    // tile controller to register decoder
    typedef struct packed {
        logic      write;
        logic      read;
        reg_addr_t address;
        cfg_data_t write_data;
    } pio_req_t;

    typedef struct packed {
        logic      ack;
        logic      nack;
        cfg_data_t read_data;
    } pio_rsp_t;

endpackage

/* glb_cfg_stim.txt */
// columns: op_addr_wdata_expected_err, err is the expected wr_drop on writes
// op 1 write, 2 read, 3 write and read in one cycle, 4 read then read while busy
// op 4 takes the second address from the low bits of the wdata column
1_004_a5a50001_00000000_0
2_004_00000000_a5a50001_0
1_0ec_0badc0de_00000000_0
2_0ec_00000000_0badc0de_0
2_030_00000000_00000000_1
2_070_00000000_00000000_1
2_0fc_00000000_00000000_1
2_100_00000000_ffffffff_1
2_1c4_00000000_ffffffff_1
1_108_12345678_00000000_1
2_008_00000000_00000000_0
1_1c4_deadbeef_00000000_1
2_004_00000000_a5a50001_0
3_088_cafef00d_00000000_0
2_088_00000000_cafef00d_0
4_004_000000ec_a5a50001_0
2_0a0_00000000_00000000_0

/* glb_cfg_top.sv */
// ========================================
// global buffer config path top level
// host port, tile chain, east terminator
// ========================================
`timescale 1ns/10ps
`include "glb_cfg_defines.svh"

module glb_cfg_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_wr,
    input  logic                   host_rd,
    input  glb_cfg_pkg::cfg_addr_t host_addr,
    input  glb_cfg_pkg::cfg_data_t host_wdata,
    output logic                   busy,
    output glb_cfg_pkg::cfg_data_t host_rdata,
    output logic                   host_rd_valid,
    output logic                   host_rd_err,
    output logic                   wr_drop
);

    // index i is the west side of tile i
    glb_cfg_pkg::cfg_wr_t  wr_bus  [`GLB_NUM_TILES+1];
    glb_cfg_pkg::cfg_rd_t  rd_bus  [`GLB_NUM_TILES+1];
    glb_cfg_pkg::cfg_rsp_t rsp_bus [`GLB_NUM_TILES+1];

    glb_host_port host_port (
        .clk           (clk),
        .reset         (reset),
        .host_wr       (host_wr),
        .host_rd       (host_rd),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .rsp_in        (rsp_bus[0]),
        .wr_out        (wr_bus[0]),
        .rd_out        (rd_bus[0]),
        .busy          (busy),
        .host_rdata    (host_rdata),
        .host_rd_valid (host_rd_valid),
        .host_rd_err   (host_rd_err)
    );

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (glb_cfg_pkg::tile_id_t'(i))
        ) tile (
            .clk     (clk),
            .reset   (reset),
            .wr_in   (wr_bus[i]),
            .rd_in   (rd_bus[i]),
            .rsp_in  (rsp_bus[i+1]),
            .wr_out  (wr_bus[i+1]),
            .rd_out  (rd_bus[i+1]),
            .rsp_out (rsp_bus[i])
        );
    end

    glb_east_term east_term (
        .clk     (clk),
        .reset   (reset),
        .wr_in   (wr_bus[`GLB_NUM_TILES]),
        .rd_in   (rd_bus[`GLB_NUM_TILES]),
        .rsp_out (rsp_bus[`GLB_NUM_TILES]),
        .wr_drop (wr_drop)
    );

endmodule

/* glb_east_term.sv */
// ========================================
// global buffer east terminator
// error responses for unclaimed reads,
// drop flag for unclaimed writes
// ========================================
`timescale 1ns/10ps

module glb_east_term (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::cfg_wr_t  wr_in,
    input  glb_cfg_pkg::cfg_rd_t  rd_in,
    output glb_cfg_pkg::cfg_rsp_t rsp_out,
    output logic                  wr_drop
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_out <= '0;
            wr_drop <= 1'b0;
        end else begin
            rsp_out <= '0;
            // no tile owns this address
            if (rd_in.en) begin
                rsp_out.valid <= 1'b1;
                rsp_out.err   <= 1'b1;
                rsp_out.data  <= '1;
            end
            wr_drop <= wr_in.en;
        end
    end

endmodule

/* glb_host_port.sv */
// ========================================
// global buffer host port
// drives the westmost config bus and
// holds one outstanding read
// ========================================
`timescale 1ns/10ps

module glb_host_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_wr,
    input  logic                   host_rd,
    input  glb_cfg_pkg::cfg_addr_t host_addr,
    input  glb_cfg_pkg::cfg_data_t host_wdata,
    input  glb_cfg_pkg::cfg_rsp_t  rsp_in,
    output glb_cfg_pkg::cfg_wr_t   wr_out,
    output glb_cfg_pkg::cfg_rd_t   rd_out,
    output logic                   busy,
    output glb_cfg_pkg::cfg_data_t host_rdata,
    output logic                   host_rd_valid,
    output logic                   host_rd_err
);

    logic rd_accept;

    // write wins over a read in the same cycle, reads need an idle port
    assign rd_accept = host_rd & ~host_wr & ~busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_out        <= '0;
            rd_out        <= '0;
            busy          <= 1'b0;
            host_rd_valid <= 1'b0;
            host_rd_err   <= 1'b0;
        end else begin
            wr_out <= '0;
            if (host_wr) begin
                wr_out.en   <= 1'b1;
                wr_out.addr <= host_addr;
                wr_out.data <= host_wdata;
            end
            rd_out <= '0;
            if (rd_accept) begin
                rd_out.en   <= 1'b1;
                rd_out.addr <= host_addr;
            end
            // busy drops together with the valid pulse
            if (rd_accept) begin
                busy <= 1'b1;
            end else if (rsp_in.valid) begin
                busy <= 1'b0;
            end
            host_rd_valid <= rsp_in.valid;
            host_rd_err   <= rsp_in.valid & rsp_in.err;
        end
    end

    // returned read word
    always_ff @(posedge clk) begin
        if (rsp_in.valid) begin
            host_rdata <= rsp_in.data;
        end
    end

endmodule

/* glb_tile.sv */
// ========================================
// global buffer tile, one chain element
// ========================================
`timescale 1ns/10ps

module glb_tile #(
    parameter glb_cfg_pkg::tile_id_t TILE_ID = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::cfg_wr_t  wr_in,
    input  glb_cfg_pkg::cfg_rd_t  rd_in,
    input  glb_cfg_pkg::cfg_rsp_t rsp_in,
    output glb_cfg_pkg::cfg_wr_t  wr_out,
    output glb_cfg_pkg::cfg_rd_t  rd_out,
    output glb_cfg_pkg::cfg_rsp_t rsp_out
);

    glb_cfg_pkg::pio_req_t pio_req;
    glb_cfg_pkg::pio_rsp_t pio_rsp;

    glb_tile_cfg_ctrl #(
        .TILE_ID (TILE_ID)
    ) cfg_ctrl (
        .clk     (clk),
        .reset   (reset),
        .wr_in   (wr_in),
        .rd_in   (rd_in),
        .rsp_in  (rsp_in),
        .pio_rsp (pio_rsp),
        .wr_out  (wr_out),
        .rd_out  (rd_out),
        .rsp_out (rsp_out),
        .pio_req (pio_req)
    );

    glb_tile_regs tile_regs (
        .clk     (clk),
        .reset   (reset),
        .pio_req (pio_req),
        .pio_rsp (pio_rsp)
    );

endmodule

/* glb_tile_cfg_ctrl.sv */
// ========================================
// global buffer tile config controller
// claims or forwards bus requests, drives
// the pio strobes, merges read responses
// ========================================
`timescale 1ns/10ps
`include "glb_cfg_defines.svh"

module glb_tile_cfg_ctrl #(
    parameter glb_cfg_pkg::tile_id_t TILE_ID = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  glb_cfg_pkg::cfg_wr_t   wr_in,
    input  glb_cfg_pkg::cfg_rd_t   rd_in,
    input  glb_cfg_pkg::cfg_rsp_t  rsp_in,
    input  glb_cfg_pkg::pio_rsp_t  pio_rsp,
    output glb_cfg_pkg::cfg_wr_t   wr_out,
    output glb_cfg_pkg::cfg_rd_t   rd_out,
    output glb_cfg_pkg::cfg_rsp_t  rsp_out,
    output glb_cfg_pkg::pio_req_t  pio_req
);

    // tile field sits above byte offset and register field
    localparam int TILE_LSB = `GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH;

    logic                  wr_match;
    logic                  rd_match;
    logic                  rd_en_d1;
    logic                  rd_en_d2;
    glb_cfg_pkg::cfg_rsp_t local_rsp;

    assign wr_match = (wr_in.addr[TILE_LSB +: `GLB_TILE_ID_WIDTH] == TILE_ID);
    assign rd_match = (rd_in.addr[TILE_LSB +: `GLB_TILE_ID_WIDTH] == TILE_ID);

    // pio strobes, write address overrides read address
    always_comb begin
        pio_req = '0;
        if (rd_in.en & rd_match) begin
            pio_req.read    = 1'b1;
            pio_req.address = rd_in.addr[`GLB_BYTE_OFFSET +: `GLB_REG_ADDR_WIDTH];
        end
        if (wr_in.en & wr_match) begin
            pio_req.write      = 1'b1;
            pio_req.address    = wr_in.addr[`GLB_BYTE_OFFSET +: `GLB_REG_ADDR_WIDTH];
            pio_req.write_data = wr_in.data;
        end
    end

    // read strobe delay lines up with the decoder ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else begin
            rd_en_d1 <= pio_req.read;
            rd_en_d2 <= rd_en_d1;
        end
    end

    // own response, nack becomes err
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            local_rsp <= '0;
        end else begin
            local_rsp <= '0;
            if (rd_en_d2 & (pio_rsp.ack | pio_rsp.nack)) begin
                local_rsp.valid <= 1'b1;
                local_rsp.err   <= pio_rsp.nack;
                local_rsp.data  <= pio_rsp.read_data;
            end
        end
    end

    // eastward forwarding of unclaimed requests
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_out <= '0;
            rd_out <= '0;
        end else begin
            wr_out <= (wr_in.en & ~wr_match) ? wr_in : '0;
            rd_out <= (rd_in.en & ~rd_match) ? rd_in : '0;
        end
    end

    // westward merge, local result ahead of east data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_out <= '0;
        end else begin
            rsp_out <= local_rsp.valid ? local_rsp : rsp_in;
        end
    end

endmodule

/* glb_tile_regs.sv */
// ========================================
// global buffer tile register decoder
// scratch words with two-stage read ack
// ========================================
`timescale 1ns/10ps
`include "glb_cfg_defines.svh"

module glb_tile_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::pio_req_t pio_req,
    output glb_cfg_pkg::pio_rsp_t pio_rsp
);

    glb_cfg_pkg::cfg_data_t  regs [`GLB_NUM_REGS];
    logic                    rd_d1;
    logic                    rd_d2;
    glb_cfg_pkg::reg_addr_t  addr_d1;
    glb_cfg_pkg::reg_addr_t  addr_d2;
    logic                    slot_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (pio_req.write && (pio_req.address < `GLB_NUM_REGS)) begin
            regs[pio_req.address] <= pio_req.write_data;
        end
    end

    // read address pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_d1   <= 1'b0;
            rd_d2   <= 1'b0;
            addr_d1 <= '0;
            addr_d2 <= '0;
        end else begin
            rd_d1   <= pio_req.read;
            rd_d2   <= rd_d1;
            addr_d1 <= pio_req.address;
            addr_d2 <= addr_d1;
        end
    end

    assign slot_ok = (addr_d2 < `GLB_NUM_REGS);

    // unimplemented slots answer nack with zero data
    assign pio_rsp.ack       = rd_d2 & slot_ok;
    assign pio_rsp.nack      = rd_d2 & ~slot_ok;
    assign pio_rsp.read_data = (rd_d2 & slot_ok) ? regs[addr_d2] : '0;

endmodule

/* tb_glb_cfg.sv */
// ========================================
// global buffer config path testbench
// stim file driven host accesses with a
// random fill sweep over all tiles
// ========================================
`timescale 1ns/10ps
`include "glb_cfg_defines.svh"

module tb_glb_cfg;

    localparam int STIM_DEPTH  = 64;
    localparam int TOTAL_SLOTS = `GLB_NUM_TILES * `GLB_NUM_REGS;
    localparam int QUIET_WAIT  = 2 * `GLB_NUM_TILES + 8;

    logic                   clk;
    logic                   reset;
    logic                   host_wr;
    logic                   host_rd;
    glb_cfg_pkg::cfg_addr_t host_addr;
    glb_cfg_pkg::cfg_data_t host_wdata;
    logic                   busy;
    glb_cfg_pkg::cfg_data_t host_rdata;
    logic                   host_rd_valid;
    logic                   host_rd_err;
    logic                   wr_drop;

    // op [83:80], addr [79:68], wdata [67:36], expected [35:4], err [3:0]
    logic [83:0]            stim_mem [STIM_DEPTH];
    glb_cfg_pkg::cfg_data_t model [`GLB_NUM_TILES][`GLB_NUM_REGS];
    int                     seed;
    int                     num_lines;

    glb_cfg_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .host_wr       (host_wr),
        .host_rd       (host_rd),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .busy          (busy),
        .host_rdata    (host_rdata),
        .host_rd_valid (host_rd_valid),
        .host_rd_err   (host_rd_err),
        .wr_drop       (wr_drop)
    );

    always #50 clk = ~clk;

    task automatic compare_data(input string name, input glb_cfg_pkg::cfg_data_t got,
                                input glb_cfg_pkg::cfg_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("watchdog expired, a read response never arrived");
        $display("Simulation failed");
        $fatal(1);
    endtask

    // byte address of a register slot in a tile
    function automatic glb_cfg_pkg::cfg_addr_t slot_addr(input int tile, input int slot);
        slot_addr = glb_cfg_pkg::cfg_addr_t'((tile << (`GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH))
                                             | (slot << `GLB_BYTE_OFFSET));
    endfunction

    task automatic host_write(input glb_cfg_pkg::cfg_addr_t addr,
                              input glb_cfg_pkg::cfg_data_t data, input logic with_read);
        @(posedge clk);
        #5;
        host_wr    = 1'b1;
        host_rd    = with_read;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        #5;
        host_wr = 1'b0;
        host_rd = 1'b0;
    endtask

    task automatic wait_response();
        @(negedge clk);
        while (host_rd_valid !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic host_read_check(input glb_cfg_pkg::cfg_addr_t addr,
                                   input glb_cfg_pkg::cfg_data_t exp, input logic exp_err);
        @(posedge clk);
        #5;
        host_rd   = 1'b1;
        host_addr = addr;
        @(posedge clk);
        #5;
        host_rd = 1'b0;
        wait_response();
        compare_flag("host_rd_err", host_rd_err, exp_err);
        compare_data("host_rdata", host_rdata, exp);
    endtask

    // no read response may show up in this window
    task automatic check_quiet(input int cycles);
        logic seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            seen = seen | host_rd_valid;
        end
        compare_flag("host_rd_valid", seen, 1'b0);
    endtask

    // unclaimed write shows up at the terminator after the whole chain
    task automatic check_drop(input logic exp);
        logic seen;
        seen = 1'b0;
        repeat (`GLB_NUM_TILES + 4) begin
            @(negedge clk);
            seen = seen | wr_drop;
        end
        compare_flag("wr_drop", seen, exp);
    endtask

    task automatic busy_read_check(input glb_cfg_pkg::cfg_addr_t first,
                                   input glb_cfg_pkg::cfg_addr_t second,
                                   input glb_cfg_pkg::cfg_data_t exp);
        @(posedge clk);
        #5;
        host_rd   = 1'b1;
        host_addr = first;
        @(posedge clk);
        #5;
        compare_flag("busy", busy, 1'b1);
        host_addr = second;
        @(posedge clk);
        #5;
        host_rd = 1'b0;
        wait_response();
        compare_flag("host_rd_err", host_rd_err, 1'b0);
        compare_data("host_rdata", host_rdata, exp);
        check_quiet(QUIET_WAIT);
    endtask

    task automatic run_stim_line(input logic [83:0] rec);
        case (rec[83:80])
            4'h1: begin
                host_write(rec[76:68], rec[67:36], 1'b0);
                check_drop(rec[0]);
            end
            4'h2: host_read_check(rec[76:68], rec[35:4], rec[0]);
            4'h3: begin
                host_write(rec[76:68], rec[67:36], 1'b1);
                check_quiet(QUIET_WAIT);
            end
            4'h4: busy_read_check(rec[76:68], rec[44:36], rec[35:4]);
            default: begin
                $display("stim file holds an unknown operation code %h", rec[83:80]);
                $display("Simulation failed");
                $fatal(1);
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'hc235_e332;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("glb_cfg_stim.txt", stim_mem);
        num_lines = 0;
        while ((num_lines < STIM_DEPTH) && (stim_mem[num_lines][83:80] != 4'h0)) begin
            num_lines++;
        end
        fork
            run_watchdog((num_lines + 3 * TOTAL_SLOTS) * 40 + 20);
        join_none
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;

        // every register reads zero out of reset
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int s = 0; s < `GLB_NUM_REGS; s++) begin
                host_read_check(slot_addr(t, s), '0, 1'b0);
            end
        end

        for (int i = 0; i < num_lines; i++) begin
            run_stim_line(stim_mem[i]);
        end

        // random fill, then read everything back
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int s = 0; s < `GLB_NUM_REGS; s++) begin
                model[t][s] = $random(seed);
                host_write(slot_addr(t, s), model[t][s], 1'b0);
                check_drop(1'b0);
            end
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int s = 0; s < `GLB_NUM_REGS; s++) begin
                host_read_check(slot_addr(t, s), model[t][s], 1'b0);
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
glb_cfg_pkg.sv
glb_host_port.sv
glb_tile_regs.sv
glb_tile_cfg_ctrl.sv
glb_tile.sv
glb_east_term.sv
glb_cfg_top.sv
glb_cfg_checker.sv
tb_glb_cfg.sv
